//--- rtl/modexp_cfg_pkg.sv
// word and big number sizes of the modular exponentiation unit
// derived widths and the word and big number types
package modexp_cfg_pkg;

	localparam int WORD_WIDTH = 16;	// bits per word
	localparam int NUM_WORDS = 4;	// words per big number
	localparam int NUM_BITS = NUM_WORDS * WORD_WIDTH;

	// word index, wide enough for NUM_WORDS + 1 (accumulator top word)
	localparam int INDEX_WIDTH = $clog2(NUM_WORDS + 2);
	localparam int BIT_INDEX_WIDTH = $clog2(NUM_BITS);	// exponent bit position

	// m, e, n, r, t words plus the single nprime0 word
	localparam int LOAD_COUNT = 5 * NUM_WORDS + 1;
	localparam int LOAD_COUNT_WIDTH = $clog2(LOAD_COUNT + 1);

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [NUM_BITS-1:0] bignum_t;	// word 0 in the low bits

endpackage

//--- rtl/modexp_ctrl_pkg.sv
// state encodings of the exponent sequencer
// and of the CIOS Montgomery product sequencer
package modexp_ctrl_pkg;

	typedef enum logic [2:0] {
		exp_idle,	// waiting for the operands
		exp_wait_compute,	// operands loaded, waiting for start
		exp_to_mont,	// m_bar = MonPro(m, t)
		exp_scan,	// look for the top set exponent bit
		exp_square,	// c_bar = MonPro(c_bar, c_bar)
		exp_multiply,	// c_bar = MonPro(c_bar, m_bar)
		exp_from_mont,	// c_bar = MonPro(1, c_bar)
		exp_done
	} exp_state_t;

	typedef enum logic [3:0] {
		mont_idle,
		mont_mul_loop,	// acc += a[i] * b
		mont_carry_fold,	// carry into the two top words
		mont_reduce_factor,	// q = acc[0] * nprime0
		mont_reduce_loop,	// acc = (acc + q * n) >> word
		mont_carry_shift,
		mont_top_fold,
		mont_next_outer,
		mont_finish
	} mont_state_t;

endpackage

//--- rtl/mul_add.sv
// registered word multiply-accumulate, x * y + z + carry_in
`timescale 1ns/1ps

module mul_add (
	input logic clk,
	input modexp_cfg_pkg::word_t x,
	input modexp_cfg_pkg::word_t y,
	input modexp_cfg_pkg::word_t z,
	input modexp_cfg_pkg::word_t carry_in,
	output modexp_cfg_pkg::word_t sum,
	output modexp_cfg_pkg::word_t carry_out
);

	logic [2*modexp_cfg_pkg::WORD_WIDTH-1:0] product;

	// the double width target widens every operand before the multiply,
	// and the largest possible value still fits in two words
	assign product = x * y + z + carry_in;

	always_ff @(posedge clk) begin
		sum <= product[modexp_cfg_pkg::WORD_WIDTH-1:0];	// low word
		carry_out <= product[2*modexp_cfg_pkg::WORD_WIDTH-1:modexp_cfg_pkg::WORD_WIDTH];
	end

endmodule

//--- rtl/operand_loader.sv
// operand loader, steers the input word stream into m, e, n, r, t and nprime0
`timescale 1ns/1ps

module operand_loader (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input modexp_cfg_pkg::word_t in_word,
	output logic loaded,
	output modexp_cfg_pkg::bignum_t m_value,
	output modexp_cfg_pkg::bignum_t e_value,
	output modexp_cfg_pkg::bignum_t n_value,
	output modexp_cfg_pkg::bignum_t r_value,
	output modexp_cfg_pkg::bignum_t t_value,
	output modexp_cfg_pkg::word_t nprime0
);

	logic [modexp_cfg_pkg::LOAD_COUNT_WIDTH-1:0] count;	// words accepted so far
	logic [modexp_cfg_pkg::LOAD_COUNT_WIDTH-1:0] operand_sel;	// which operand
	logic [modexp_cfg_pkg::INDEX_WIDTH-1:0] word_slot;	// which word of it
	logic accept;

	assign accept = in_valid && !loaded;	// loaded doubles as the full flag
	assign operand_sel = (modexp_cfg_pkg::LOAD_COUNT_WIDTH)'(count / modexp_cfg_pkg::NUM_WORDS);
	assign word_slot = (modexp_cfg_pkg::INDEX_WIDTH)'(count % modexp_cfg_pkg::NUM_WORDS);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			loaded <= 1'b0;
		end else if (accept) begin
			count <= count + 1'b1;
			if (count == (modexp_cfg_pkg::LOAD_COUNT_WIDTH)'(modexp_cfg_pkg::LOAD_COUNT - 1))
				loaded <= 1'b1;	// last word taken, held until reset
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			case (operand_sel)
				0: m_value[modexp_cfg_pkg::WORD_WIDTH*word_slot +: modexp_cfg_pkg::WORD_WIDTH]
					<= in_word;
				1: e_value[modexp_cfg_pkg::WORD_WIDTH*word_slot +: modexp_cfg_pkg::WORD_WIDTH]
					<= in_word;
				2: n_value[modexp_cfg_pkg::WORD_WIDTH*word_slot +: modexp_cfg_pkg::WORD_WIDTH]
					<= in_word;
				3: r_value[modexp_cfg_pkg::WORD_WIDTH*word_slot +: modexp_cfg_pkg::WORD_WIDTH]
					<= in_word;
				4: t_value[modexp_cfg_pkg::WORD_WIDTH*word_slot +: modexp_cfg_pkg::WORD_WIDTH]
					<= in_word;
				default: nprime0 <= in_word;	// final single word
			endcase
		end
	end

endmodule

//--- rtl/montgomery_multiplier.sv
// CIOS Montgomery product a * b / R mod n, one word step per two cycles
// all arithmetic goes through a single mul_add
`timescale 1ns/1ps

module montgomery_multiplier (
	input logic clk,
	input logic reset,
	input logic start,
	input modexp_cfg_pkg::bignum_t a_value,
	input modexp_cfg_pkg::bignum_t b_value,
	input modexp_cfg_pkg::bignum_t n_value,
	input modexp_cfg_pkg::word_t nprime0,
	output logic mont_done,
	output modexp_cfg_pkg::bignum_t mont_result
);

	modexp_ctrl_pkg::mont_state_t state;
	logic phase;	// 0 = operands go in, 1 = result comes back
	logic arith;
	logic [modexp_cfg_pkg::INDEX_WIDTH-1:0] i;	// outer word of a
	logic [modexp_cfg_pkg::INDEX_WIDTH-1:0] j;	// inner word
	modexp_cfg_pkg::word_t acc [0:modexp_cfg_pkg::NUM_WORDS+1];
	modexp_cfg_pkg::word_t carry;
	modexp_cfg_pkg::word_t factor;	// reduction factor q
	modexp_cfg_pkg::word_t x, y, z, carry_in;
	modexp_cfg_pkg::word_t sum, carry_out;

	mul_add i_mul_add (
		.clk(clk),
		.x(x),
		.y(y),
		.z(z),
		.carry_in(carry_in),
		.sum(sum),
		.carry_out(carry_out)
	);

	assign arith = state inside {modexp_ctrl_pkg::mont_mul_loop, modexp_ctrl_pkg::mont_carry_fold,
		modexp_ctrl_pkg::mont_reduce_factor, modexp_ctrl_pkg::mont_reduce_loop,
		modexp_ctrl_pkg::mont_carry_shift, modexp_ctrl_pkg::mont_top_fold};

	// operand select, stable over both cycles of a step
	always_comb begin
		x = '0;
		y = '0;
		z = '0;
		carry_in = carry;
		case (state)
			modexp_ctrl_pkg::mont_mul_loop: begin
				x = a_value[modexp_cfg_pkg::WORD_WIDTH*i +: modexp_cfg_pkg::WORD_WIDTH];
				y = b_value[modexp_cfg_pkg::WORD_WIDTH*j +: modexp_cfg_pkg::WORD_WIDTH];
				z = acc[j];
			end
			modexp_ctrl_pkg::mont_carry_fold,
			modexp_ctrl_pkg::mont_carry_shift: z = acc[modexp_cfg_pkg::NUM_WORDS];
			modexp_ctrl_pkg::mont_reduce_factor: begin
				x = acc[0];
				y = nprime0;
				carry_in = '0;	// only the low word is kept
			end
			modexp_ctrl_pkg::mont_reduce_loop: begin
				x = factor;
				y = n_value[modexp_cfg_pkg::WORD_WIDTH*j +: modexp_cfg_pkg::WORD_WIDTH];
				z = acc[j];
			end
			modexp_ctrl_pkg::mont_top_fold: z = acc[modexp_cfg_pkg::NUM_WORDS+1];
			default: carry_in = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= modexp_ctrl_pkg::mont_idle;
			phase <= 1'b0;
			i <= '0;
			j <= '0;
			mont_done <= 1'b0;
		end else begin
			mont_done <= 1'b0;
			phase <= arith && !phase;
			case (state)
				modexp_ctrl_pkg::mont_idle: if (start) begin
					i <= '0;
					j <= '0;
					state <= modexp_ctrl_pkg::mont_mul_loop;
				end
				modexp_ctrl_pkg::mont_mul_loop: if (phase) begin
					j <= (j == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS - 1)) ?
						'0 : j + 1'b1;
					if (j == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS - 1))
						state <= modexp_ctrl_pkg::mont_carry_fold;
				end
				modexp_ctrl_pkg::mont_carry_fold: if (phase)
					state <= modexp_ctrl_pkg::mont_reduce_factor;
				modexp_ctrl_pkg::mont_reduce_factor: if (phase)
					state <= modexp_ctrl_pkg::mont_reduce_loop;
				modexp_ctrl_pkg::mont_reduce_loop: if (phase) begin
					j <= (j == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS - 1)) ?
						'0 : j + 1'b1;
					if (j == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS - 1))
						state <= modexp_ctrl_pkg::mont_carry_shift;
				end
				modexp_ctrl_pkg::mont_carry_shift: if (phase)
					state <= modexp_ctrl_pkg::mont_top_fold;
				modexp_ctrl_pkg::mont_top_fold: if (phase)
					state <= modexp_ctrl_pkg::mont_next_outer;
				modexp_ctrl_pkg::mont_next_outer: begin
					if (i == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS - 1)) begin
						state <= modexp_ctrl_pkg::mont_finish;
					end else begin
						i <= i + 1'b1;
						state <= modexp_ctrl_pkg::mont_mul_loop;
					end
				end
				default: begin	// mont_finish
					mont_done <= 1'b1;
					state <= modexp_ctrl_pkg::mont_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == modexp_ctrl_pkg::mont_idle && start) begin
			acc <= '{default: '0};	// fresh accumulator per product
			carry <= '0;
		end else if (phase) begin
			case (state)
				modexp_ctrl_pkg::mont_mul_loop: begin
					acc[j] <= sum;
					carry <= carry_out;
				end
				modexp_ctrl_pkg::mont_carry_fold: begin
					acc[modexp_cfg_pkg::NUM_WORDS] <= sum;
					acc[modexp_cfg_pkg::NUM_WORDS+1] <= carry_out;
				end
				modexp_ctrl_pkg::mont_reduce_factor: begin
					factor <= sum;
					carry <= '0;
				end
				modexp_ctrl_pkg::mont_reduce_loop: begin
					if (j != '0)
						acc[j - 1'b1] <= sum;	// word 0 is zero and drops out
					carry <= carry_out;
				end
				modexp_ctrl_pkg::mont_carry_shift: begin
					acc[modexp_cfg_pkg::NUM_WORDS-1] <= sum;
					carry <= carry_out;
				end
				modexp_ctrl_pkg::mont_top_fold: begin
					acc[modexp_cfg_pkg::NUM_WORDS] <= sum;
					carry <= '0;	// next outer word starts clean
				end
				default: ;
			endcase
		end
		if (state == modexp_ctrl_pkg::mont_finish) begin
			for (int k = 0; k < modexp_cfg_pkg::NUM_WORDS; k++)
				mont_result[modexp_cfg_pkg::WORD_WIDTH*k +: modexp_cfg_pkg::WORD_WIDTH] <= acc[k];
		end
	end

endmodule

//--- rtl/exp_controller.sv
// left to right square and multiply sequencer in Montgomery form
`timescale 1ns/1ps

module exp_controller (
	input logic clk,
	input logic reset,
	input logic start_compute,
	input logic loaded,
	input logic mont_done,
	input modexp_cfg_pkg::bignum_t m_value,
	input modexp_cfg_pkg::bignum_t e_value,
	input modexp_cfg_pkg::bignum_t r_value,
	input modexp_cfg_pkg::bignum_t t_value,
	input modexp_cfg_pkg::bignum_t mont_result,
	output logic mont_start,
	output logic busy,
	output logic done,
	output modexp_cfg_pkg::bignum_t a_value,
	output modexp_cfg_pkg::bignum_t b_value,
	output modexp_cfg_pkg::bignum_t result_value
);

	modexp_ctrl_pkg::exp_state_t state;
	modexp_cfg_pkg::bignum_t m_bar;
	modexp_cfg_pkg::bignum_t c_bar;
	logic [modexp_cfg_pkg::BIT_INDEX_WIDTH-1:0] bit_index;
	logic requested;	// product of this state is in flight
	logic product_state;
	logic product_done;
	logic last_bit;

	assign product_state = state inside {modexp_ctrl_pkg::exp_to_mont,
		modexp_ctrl_pkg::exp_square, modexp_ctrl_pkg::exp_multiply,
		modexp_ctrl_pkg::exp_from_mont};
	assign product_done = requested && mont_done;
	assign last_bit = bit_index == '0;
	assign result_value = c_bar;

	always_comb begin
		case (state)
			modexp_ctrl_pkg::exp_to_mont: begin
				a_value = m_value;
				b_value = t_value;
			end
			modexp_ctrl_pkg::exp_multiply: begin
				a_value = c_bar;
				b_value = m_bar;
			end
			modexp_ctrl_pkg::exp_from_mont: begin
				a_value = modexp_cfg_pkg::bignum_t'(1);	// strips the R factor
				b_value = c_bar;
			end
			default: begin	// squaring
				a_value = c_bar;
				b_value = c_bar;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= modexp_ctrl_pkg::exp_idle;
			mont_start <= 1'b0;
			requested <= 1'b0;
			bit_index <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			mont_start <= 1'b0;
			if (product_state && !requested) begin
				mont_start <= 1'b1;	// one request per product state visit
				requested <= 1'b1;
			end
			if (product_done)
				requested <= 1'b0;
			case (state)
				modexp_ctrl_pkg::exp_idle: if (loaded)
					state <= modexp_ctrl_pkg::exp_wait_compute;
				modexp_ctrl_pkg::exp_wait_compute: if (start_compute && loaded) begin
					busy <= 1'b1;
					state <= modexp_ctrl_pkg::exp_to_mont;
				end
				modexp_ctrl_pkg::exp_to_mont: if (product_done) begin
					bit_index <= '1;	// top exponent bit
					state <= modexp_ctrl_pkg::exp_scan;
				end
				modexp_ctrl_pkg::exp_scan: begin
					if (e_value[bit_index])
						state <= modexp_ctrl_pkg::exp_square;
					else if (last_bit)
						state <= modexp_ctrl_pkg::exp_from_mont;	// e is zero
					else
						bit_index <= bit_index - 1'b1;
				end
				modexp_ctrl_pkg::exp_square: if (product_done) begin
					if (e_value[bit_index])
						state <= modexp_ctrl_pkg::exp_multiply;
					else if (last_bit)
						state <= modexp_ctrl_pkg::exp_from_mont;
					else
						bit_index <= bit_index - 1'b1;	// square again
				end
				modexp_ctrl_pkg::exp_multiply: if (product_done) begin
					if (last_bit) begin
						state <= modexp_ctrl_pkg::exp_from_mont;
					end else begin
						bit_index <= bit_index - 1'b1;
						state <= modexp_ctrl_pkg::exp_square;
					end
				end
				modexp_ctrl_pkg::exp_from_mont: if (product_done) begin
					busy <= 1'b0;
					done <= 1'b1;
					state <= modexp_ctrl_pkg::exp_done;
				end
				default: ;	// exp_done holds until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (product_done) begin
			if (state == modexp_ctrl_pkg::exp_to_mont) begin
				m_bar <= mont_result;
				c_bar <= r_value;	// R mod n is 1 in Montgomery form
			end else begin
				c_bar <= mont_result;
			end
		end
	end

endmodule

//--- rtl/result_streamer.sv
// streams the result words out, least significant first, on each request
`timescale 1ns/1ps

module result_streamer (
	input logic clk,
	input logic reset,
	input logic get_result,
	input logic done,
	input modexp_cfg_pkg::bignum_t result_value,
	output logic out_valid,
	output modexp_cfg_pkg::word_t out_word
);

	logic [modexp_cfg_pkg::INDEX_WIDTH-1:0] word_index;	// next word to send

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			word_index <= '0;
			out_valid <= 1'b0;
			out_word <= '0;
		end else if (!out_valid) begin
			if (get_result && done) begin
				out_valid <= 1'b1;
				out_word <= result_value[modexp_cfg_pkg::WORD_WIDTH-1:0];
				word_index <= (modexp_cfg_pkg::INDEX_WIDTH)'(1);
			end
		end else if (word_index == (modexp_cfg_pkg::INDEX_WIDTH)'(modexp_cfg_pkg::NUM_WORDS)) begin
			out_valid <= 1'b0;	// stream complete
			out_word <= '0;
			word_index <= '0;
		end else begin
			out_word <= result_value[modexp_cfg_pkg::WORD_WIDTH*word_index +:
				modexp_cfg_pkg::WORD_WIDTH];
			word_index <= word_index + 1'b1;
		end
	end

endmodule

//--- rtl/modexp_top.sv
// modular exponentiation top, loader, sequencers and result streamer
`timescale 1ns/1ps

module modexp_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic start_compute,
	input logic get_result,
	input modexp_cfg_pkg::word_t in_word,
	output logic busy,
	output logic done,
	output logic out_valid,
	output modexp_cfg_pkg::word_t out_word
);

	logic loaded;
	logic mont_start;
	logic mont_done;
	modexp_cfg_pkg::bignum_t m_value, e_value, n_value, r_value, t_value;
	modexp_cfg_pkg::word_t nprime0;
	modexp_cfg_pkg::bignum_t a_value, b_value;
	modexp_cfg_pkg::bignum_t mont_result;
	modexp_cfg_pkg::bignum_t result_value;	// c_bar

	operand_loader i_operand_loader (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_word(in_word), .loaded(loaded),
		.m_value(m_value), .e_value(e_value), .n_value(n_value),
		.r_value(r_value), .t_value(t_value), .nprime0(nprime0)
	);

	exp_controller i_exp_controller (
		.clk(clk), .reset(reset),
		.start_compute(start_compute), .loaded(loaded), .mont_done(mont_done),
		.m_value(m_value), .e_value(e_value), .r_value(r_value), .t_value(t_value),
		.mont_result(mont_result), .mont_start(mont_start),
		.busy(busy), .done(done),
		.a_value(a_value), .b_value(b_value), .result_value(result_value)
	);

	montgomery_multiplier i_montgomery_multiplier (
		.clk(clk), .reset(reset), .start(mont_start),
		.a_value(a_value), .b_value(b_value), .n_value(n_value), .nprime0(nprime0),
		.mont_done(mont_done), .mont_result(mont_result)
	);

	result_streamer i_result_streamer (
		.clk(clk), .reset(reset),
		.get_result(get_result), .done(done), .result_value(result_value),
		.out_valid(out_valid), .out_word(out_word)
	);

endmodule

//--- verification/tb_clock.sv
// clock and reset source for the testbench
// reset is raised again for 4 cycles on a restart request
`timescale 1ns/1ps

module tb_clock (
	input logic restart,
	output logic clk,
	output logic reset
);

	int unsigned reset_cycles = 4;	// reset cycles still to go

	initial clk = 1'b0;
	always #5 clk = ~clk;	// 10 ns period

	always @(posedge clk) begin
		if (restart)
			reset_cycles <= 4;
		else if (reset_cycles != 0)
			reset_cycles <= reset_cycles - 1;
	end

	assign reset = reset_cycles != 0;

endmodule

//--- verification/tb_modexp.sv
// testbench for the modular exponentiation unit
// seeded random operands, square and multiply reference model, stream checks
`timescale 1ns/1ps

module tb_modexp;

	localparam int DONE_TIMEOUT = 40000;	// cycles, covers 2 products per exponent bit
	localparam int STREAM_TIMEOUT = 20;
	localparam int RESET_TIMEOUT = 20;
	localparam int RANDOM_CASES = 20;
	localparam int WW = modexp_cfg_pkg::WORD_WIDTH;
	localparam int NW = modexp_cfg_pkg::NUM_WORDS;

	logic clk, reset, restart;
	logic in_valid, start_compute, get_result;
	modexp_cfg_pkg::word_t in_word;
	logic busy, done, out_valid;
	modexp_cfg_pkg::word_t out_word;

	modexp_cfg_pkg::word_t load_words[$];	// m, e, n, r, t, nprime0 in stream order
	string current_test;
	int test_errors;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock i_tb_clock (.restart(restart), .clk(clk), .reset(reset));

	modexp_top i_modexp_top (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .start_compute(start_compute), .get_result(get_result),
		.in_word(in_word), .busy(busy), .done(done),
		.out_valid(out_valid), .out_word(out_word)
	);

	task automatic step();
		@(posedge clk);
		#1;	// inputs change and outputs are read here
	endtask

	task automatic report_error(string text);
		$display("%s: %s", current_test, text);
		test_errors++;
	endtask

	task automatic check_flag(string what, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %b, actual %b", current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_word(string what, modexp_cfg_pkg::word_t expected,
		modexp_cfg_pkg::word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %h, actual %h", current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_value(string what, modexp_cfg_pkg::bignum_t expected,
		modexp_cfg_pkg::bignum_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %h, actual %h", current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	function automatic modexp_cfg_pkg::bignum_t mul_mod(modexp_cfg_pkg::bignum_t a,
		modexp_cfg_pkg::bignum_t b, modexp_cfg_pkg::bignum_t n);
		logic [2*modexp_cfg_pkg::NUM_BITS-1:0] wide;
		wide = (2*modexp_cfg_pkg::NUM_BITS)'(a) * (2*modexp_cfg_pkg::NUM_BITS)'(b);
		return modexp_cfg_pkg::bignum_t'(wide % (2*modexp_cfg_pkg::NUM_BITS)'(n));
	endfunction

	// left to right square and multiply over all exponent bits
	function automatic modexp_cfg_pkg::bignum_t power_mod(modexp_cfg_pkg::bignum_t m,
		modexp_cfg_pkg::bignum_t e, modexp_cfg_pkg::bignum_t n);
		modexp_cfg_pkg::bignum_t result;
		result = 1;
		for (int k = modexp_cfg_pkg::NUM_BITS - 1; k >= 0; k--) begin
			result = mul_mod(result, result, n);
			if (e[k])
				result = mul_mod(result, m, n);
		end
		return result;
	endfunction

	// Newton iteration, an odd word is its own inverse to 3 bits
	function automatic modexp_cfg_pkg::word_t neg_inverse(modexp_cfg_pkg::word_t n0);
		modexp_cfg_pkg::word_t inv;
		inv = n0;
		repeat (4)
			inv = modexp_cfg_pkg::word_t'(inv * (2 - n0 * inv));
		return -inv;
	endfunction

	function automatic modexp_cfg_pkg::bignum_t random_value();
		modexp_cfg_pkg::bignum_t value;
		for (int k = 0; k < NW; k++)
			value[WW*k +: WW] = modexp_cfg_pkg::word_t'($urandom());
		return value;
	endfunction

	// two top bits clear keeps 4n below R, so unreduced products fit in NUM_BITS
	function automatic modexp_cfg_pkg::bignum_t random_modulus();
		modexp_cfg_pkg::bignum_t n;
		n = random_value();
		n[modexp_cfg_pkg::NUM_BITS-1 -: 2] = 2'b00;
		n[modexp_cfg_pkg::NUM_BITS-3] = 1'b1;
		n[0] = 1'b1;	// odd modulus
		return n;
	endfunction

	task automatic push_value(modexp_cfg_pkg::bignum_t value);
		for (int k = 0; k < NW; k++)
			load_words.push_back(value[WW*k +: WW]);	// least significant first
	endtask

	task automatic build_load_words(modexp_cfg_pkg::bignum_t m, modexp_cfg_pkg::bignum_t e,
		modexp_cfg_pkg::bignum_t n);
		logic [2*modexp_cfg_pkg::NUM_BITS-1:0] big_r;
		modexp_cfg_pkg::bignum_t r;
		modexp_cfg_pkg::bignum_t t;
		big_r = '0;
		big_r[modexp_cfg_pkg::NUM_BITS] = 1'b1;	// R
		r = modexp_cfg_pkg::bignum_t'(big_r % (2*modexp_cfg_pkg::NUM_BITS)'(n));
		t = mul_mod(r, r, n);
		load_words.delete();
		push_value(m);
		push_value(e);
		push_value(n);
		push_value(r);
		push_value(t);
		load_words.push_back(neg_inverse(n[WW-1:0]));
	endtask

	// random idle cycles between words, junk on in_word while idle
	task automatic send_words(int first, int last);
		int k;
		k = first;
		while (k < last) begin
			if ($urandom_range(3) == 0) begin
				in_valid = 1'b0;
				in_word = modexp_cfg_pkg::word_t'($urandom());
			end else begin
				in_valid = 1'b1;
				in_word = load_words[k];
				k++;
			end
			step();
		end
		in_valid = 1'b0;
		in_word = '0;
	endtask

	task automatic reset_dut();
		int waited;
		restart = 1'b1;
		step();
		restart = 1'b0;
		waited = 0;
		while (reset && waited < RESET_TIMEOUT) begin
			step();
			waited++;
		end
		if (reset)
			report_error("reset did not release");
	endtask

	task automatic wait_done(output logic ok);
		int waited;
		waited = 0;
		while (!done && waited < DONE_TIMEOUT) begin
			step();
			waited++;
		end
		if (!done)
			report_error($sformatf("done did not rise within %0d cycles", DONE_TIMEOUT));
		ok = done;
	endtask

	task automatic read_result(output modexp_cfg_pkg::bignum_t value);
		int waited;
		int count;
		value = '0;
		get_result = 1'b1;
		step();
		get_result = 1'b0;
		waited = 1;
		while (!out_valid && waited < STREAM_TIMEOUT) begin
			step();
			waited++;
		end
		if (!out_valid) begin
			report_error("out_valid did not rise after get_result");
			return;
		end
		if (waited != 1)
			report_error($sformatf("out_valid rose %0d cycles after get_result, not 1", waited));
		count = 0;
		while (out_valid && count <= NW) begin
			if (count < NW)
				value[WW*count +: WW] = out_word;
			count++;
			step();
		end
		if (count != NW)
			report_error($sformatf("out_valid held for %0d cycles instead of %0d", count, NW));
		check_word("out_word between streams", '0, out_word);
	endtask

	task automatic finish_test();
		tests_run++;
		error_count += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %s: %0d errors", current_test, test_errors);
		end else begin
			$display("test %s: ok", current_test);
		end
	endtask

	task automatic run_case(string name, modexp_cfg_pkg::bignum_t m,
		modexp_cfg_pkg::bignum_t e, modexp_cfg_pkg::bignum_t n, logic early_start);
		modexp_cfg_pkg::bignum_t expected;
		modexp_cfg_pkg::bignum_t first;
		modexp_cfg_pkg::bignum_t second;
		logic ok;
		current_test = name;
		test_errors = 0;
		reset_dut();
		build_load_words(m, e, n);
		expected = power_mod(m, e, n);
		if (early_start) begin
			send_words(0, modexp_cfg_pkg::LOAD_COUNT / 2);
			start_compute = 1'b1;	// operands incomplete, must be ignored
			step();
			start_compute = 1'b0;
			step();
			check_flag("busy after early start", 1'b0, busy);
			send_words(modexp_cfg_pkg::LOAD_COUNT / 2, modexp_cfg_pkg::LOAD_COUNT);
		end else begin
			send_words(0, modexp_cfg_pkg::LOAD_COUNT);
		end
		step();	// controller moves to wait_compute after loaded
		step();
		check_flag("busy before start", 1'b0, busy);
		start_compute = 1'b1;
		step();
		start_compute = 1'b0;
		check_flag("busy after start", 1'b1, busy);
		wait_done(ok);
		if (ok) begin
			check_flag("busy at done", 1'b0, busy);
			read_result(first);
			check_value("result mod n", expected, first % n);
			read_result(second);
			for (int k = 0; k < NW; k++)
				check_word($sformatf("repeated word %0d", k), first[WW*k +: WW], second[WW*k +: WW]);
		end
		finish_test();
	endtask

	initial begin
		modexp_cfg_pkg::bignum_t m;
		modexp_cfg_pkg::bignum_t e;
		modexp_cfg_pkg::bignum_t n;
		void'($urandom(32'h9d513ed5));
		restart = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		start_compute = 1'b0;
		get_result = 1'b0;

		current_test = "reset_state";
		test_errors = 0;
		reset_dut();
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("out_valid", 1'b0, out_valid);
		check_word("out_word", '0, out_word);
		finish_test();

		for (int i = 0; i < RANDOM_CASES; i++) begin
			n = random_modulus();
			m = random_value() % n;
			e = random_value();
			run_case($sformatf("random_%02d", i), m, e, n, 1'b0);
		end

		n = random_modulus();
		m = random_value() % n;
		run_case("exponent_one", m, 1, n, 1'b0);
		run_case("exponent_zero", m, 0, n, 1'b0);

		n = random_modulus();
		m = random_value() % n;
		e = random_value();
		run_case("early_start", m, e, n, 1'b1);

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tb.f
rtl/modexp_cfg_pkg.sv
rtl/modexp_ctrl_pkg.sv
rtl/mul_add.sv
rtl/operand_loader.sv
rtl/montgomery_multiplier.sv
rtl/exp_controller.sv
rtl/result_streamer.sv
rtl/modexp_top.sv
verification/tb_clock.sv
verification/tb_modexp.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_modexp
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
